// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpuTopTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for a pass"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/aluUnit.sv
`default_nettype none

module aluUnit (
    input  legPkg::wordT  a,
    input  legPkg::wordT  b,
    input  legPkg::aluOpT op,
    output legPkg::wordT  result,
    output logic          zero,
    output logic          negative,
    output logic          overflow,
    output logic          carry
);
    import legPkg::*;

    wordT        bOperand;
    logic        carryIn;
    logic        isArith;
    logic [64:0] sum;

    assign isArith = (op == ALU_ADD) || (op == ALU_SUB);

    // Subtract as a + ~b + 1
    always_comb begin
        if (op == ALU_SUB) begin
            bOperand = ~b;
            carryIn  = 1'b1;
        end else begin
            bOperand = b;
            carryIn  = 1'b0;
        end
    end

    assign sum = {1'b0, a} + {1'b0, bOperand} + {64'd0, carryIn};

    always_comb begin
        if (isArith) begin
            result   = sum[63:0];
            carry    = sum[64];  // High means no borrow on SUBS
            overflow = (a[63] == bOperand[63]) && (sum[63] != a[63]);
        end else begin
            result   = b;  // Pass-B for CBZ and unused codes
            carry    = 1'b0;
            overflow = 1'b0;
        end
    end

    assign zero     = (result == '0);
    assign negative = result[63];

endmodule

`default_nettype wire

// File: logic/controlDecoder.sv
`default_nettype none

module controlDecoder (
    input  logic [10:0]    opcode,
    input  logic           condZero,   // Live ALU zero, for CBZ
    input  logic           flagNeg,
    input  logic           flagOvf,
    output logic           reg2Loc,
    output logic           reg2Write,
    output logic           regWrite,
    output logic           memWrite,
    output logic           uncondBr,
    output logic           updateFlag,
    output legPkg::brSelT  brSel,
    output legPkg::aluSrcT aluSrc,
    output legPkg::wbSelT  wbSel,
    output legPkg::aluOpT  aluOp
);
    import legPkg::*;

    logic ltTaken;

    assign ltTaken = flagNeg ^ flagOvf;  // Signed less-than from stored flags

    always_comb begin
        // Safe values, so anything not listed below is a no-op
        reg2Loc    = 1'b0;
        reg2Write  = 1'b0;
        regWrite   = 1'b0;
        memWrite   = 1'b0;
        uncondBr   = 1'b0;
        updateFlag = 1'b0;
        brSel      = BR_NONE;
        aluSrc     = SRC_REG;
        wbSel      = WB_ALU;
        aluOp      = ALU_PASS_B;

        priority casez (opcode)
            {OP_B, 5'b?????}: begin
                brSel    = BR_PCREL;
                uncondBr = 1'b1;
            end
            {OP_BLT, 3'b???}: begin
                brSel = ltTaken ? BR_PCREL : BR_NONE;
            end
            {OP_BL, 5'b?????}: begin
                brSel     = BR_PCREL;
                uncondBr  = 1'b1;
                regWrite  = 1'b1;
                reg2Write = 1'b1;  // Destination forced to X30
                wbSel     = WB_LINK;
            end
            OP_BR: begin
                brSel = BR_REG;  // Target register in bits 4:0, via port B
            end
            {OP_CBZ, 3'b???}: begin
                aluOp = ALU_PASS_B;  // Rt through the ALU to get zero
                brSel = condZero ? BR_PCREL : BR_NONE;
            end
            {OP_ADDI, 1'b?}: begin
                aluOp    = ALU_ADD;
                aluSrc   = SRC_IMM12;
                regWrite = 1'b1;
            end
            OP_ADDS: begin
                aluOp      = ALU_ADD;
                reg2Loc    = 1'b1;
                regWrite   = 1'b1;
                updateFlag = 1'b1;
            end
            OP_SUBS: begin
                aluOp      = ALU_SUB;
                reg2Loc    = 1'b1;
                regWrite   = 1'b1;
                updateFlag = 1'b1;
            end
            OP_LDUR: begin
                aluOp    = ALU_ADD;
                aluSrc   = SRC_DADDR9;
                regWrite = 1'b1;
                wbSel    = WB_MEM;
            end
            OP_STUR: begin
                aluOp    = ALU_ADD;
                aluSrc   = SRC_DADDR9;
                memWrite = 1'b1;  // Store data is Rt on port B
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        assert (!(memWrite && regWrite))
            else $error("controlDecoder: memWrite and regWrite both set");
    end

endmodule

`default_nettype wire

// File: logic/cpuTop.sv
`default_nettype none

module cpuTop #(
    parameter legPkg::wordT RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rstN,
    output legPkg::wordT  imemAddr,
    input  legPkg::instrT imemData,
    output legPkg::wordT  dmemAddr,
    output legPkg::wordT  dmemWrData,
    output logic          dmemWrEn,
    input  legPkg::wordT  dmemRdData
);
    import legPkg::*;

    logic   reg2Loc, reg2Write, regWrite, memWrite, uncondBr, updateFlag;
    brSelT  brSel;
    aluSrcT aluSrc;
    wbSelT  wbSel;
    aluOpT  aluOp;

    regIdxT rdIdxB, wrIdx;
    wordT   rdDataA, rdDataB, wrData;
    wordT   aluB, aluResult, imm12, daddr9;
    wordT   pc, pcPlus4;
    logic   aluZero, aluNeg, aluOvf, aluCarry;
    logic   flagZero, flagNeg, flagOvf, flagCarry;

    controlDecoder controlDecoder_i (
        .opcode     (imemData[31:21]),
        .condZero   (aluZero),
        .flagNeg    (flagNeg),
        .flagOvf    (flagOvf),
        .reg2Loc    (reg2Loc),
        .reg2Write  (reg2Write),
        .regWrite   (regWrite),
        .memWrite   (memWrite),
        .uncondBr   (uncondBr),
        .updateFlag (updateFlag),
        .brSel      (brSel),
        .aluSrc     (aluSrc),
        .wbSel      (wbSel),
        .aluOp      (aluOp)
    );

    assign rdIdxB = reg2Loc ? imemData[20:16] : imemData[4:0];  // Rm or Rt
    assign wrIdx  = reg2Write ? LINK_REG : imemData[4:0];

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rdIdxA  (imemData[9:5]),
        .rdIdxB  (rdIdxB),
        .wrIdx   (wrIdx),
        .wrEn    (regWrite),
        .wrData  (wrData),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    assign imm12  = {52'd0, imemData[21:10]};
    assign daddr9 = {{55{imemData[20]}}, imemData[20:12]};

    always_comb begin
        case (aluSrc)
            SRC_IMM12:  aluB = imm12;
            SRC_DADDR9: aluB = daddr9;
            default:    aluB = rdDataB;
        endcase
    end

    aluUnit aluUnit_i (
        .a        (rdDataA),
        .b        (aluB),
        .op       (aluOp),
        .result   (aluResult),
        .zero     (aluZero),
        .negative (aluNeg),
        .overflow (aluOvf),
        .carry    (aluCarry)
    );

    always_comb begin
        case (wbSel)
            WB_MEM:  wrData = dmemRdData;
            WB_LINK: wrData = pcPlus4;
            default: wrData = aluResult;
        endcase
    end

    // Flag register written by ADDS/SUBS only
    always_ff @(posedge clk) begin
        if (!rstN) begin
            {flagZero, flagNeg, flagOvf, flagCarry} <= 4'b0000;
        end else if (updateFlag) begin
            {flagZero, flagNeg, flagOvf, flagCarry} <= {aluZero, aluNeg, aluOvf, aluCarry};
        end
    end

    nextPcUnit #(
        .RESET_PC (RESET_PC)
    ) nextPcUnit_i (
        .clk       (clk),
        .rstN      (rstN),
        .brSel     (brSel),
        .uncondBr  (uncondBr),
        .instr     (imemData),
        .regTarget (rdDataB),
        .pc        (pc),
        .pcPlus4   (pcPlus4)
    );

    assign imemAddr   = pc;
    assign dmemAddr   = aluResult;
    assign dmemWrData = rdDataB;
    assign dmemWrEn   = memWrite && rstN;  // No stores while held in reset

endmodule

`default_nettype wire

// File: logic/legPkg.sv
`default_nettype none

package legPkg;

    typedef logic [63:0] wordT;
    typedef logic [31:0] instrT;
    typedef logic [4:0]  regIdxT;
    typedef logic [2:0]  aluOpT;

    localparam aluOpT ALU_PASS_B = 3'b000;
    localparam aluOpT ALU_ADD    = 3'b010;
    localparam aluOpT ALU_SUB    = 3'b011;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_PCREL,
        BR_REG
    } brSelT;

    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM12,   // ALU immediate, zero-extended
        SRC_DADDR9   // Load/store offset, sign-extended
    } aluSrcT;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK
    } wbSelT;

    localparam regIdxT LINK_REG = 5'd30;
    localparam regIdxT ZERO_REG = 5'd31;

    // Fixed opcode bits, left-aligned in instr[31:21]; shorter ones are
    // followed by immediate or condition bits
    localparam logic [5:0]  OP_B    = 6'b000101;
    localparam logic [7:0]  OP_BLT  = 8'b01010100;  // B.cond, treated as B.LT
    localparam logic [5:0]  OP_BL   = 6'b100101;
    localparam logic [10:0] OP_BR   = 11'b11010110000;
    localparam logic [7:0]  OP_CBZ  = 8'b10110100;
    localparam logic [9:0]  OP_ADDI = 10'b1001000100;
    localparam logic [10:0] OP_ADDS = 11'b10101011000;
    localparam logic [10:0] OP_SUBS = 11'b11101011000;
    localparam logic [10:0] OP_LDUR = 11'b11111000010;
    localparam logic [10:0] OP_STUR = 11'b11111000000;

endpackage

`default_nettype wire

// File: logic/nextPcUnit.sv
`default_nettype none

module nextPcUnit #(
    parameter legPkg::wordT RESET_PC = '0
) (
    input  logic           clk,
    input  logic           rstN,
    input  legPkg::brSelT  brSel,
    input  logic           uncondBr,
    input  legPkg::instrT  instr,
    input  legPkg::wordT   regTarget,
    output legPkg::wordT   pc,
    output legPkg::wordT   pcPlus4
);
    import legPkg::*;

    wordT brOffset;
    wordT nextPc;

    assign pcPlus4 = pc + 64'd4;

    // 26-bit field for B/BL, 19-bit field for B.cond and CBZ
    always_comb begin
        if (uncondBr) begin
            brOffset = {{38{instr[25]}}, instr[25:0]};
        end else begin
            brOffset = {{45{instr[23]}}, instr[23:5]};
        end
    end

    always_comb begin
        case (brSel)
            BR_PCREL: nextPc = pc + (brOffset << 2);
            BR_REG:   nextPc = regTarget;
            default:  nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    // Also catches a BR to a misaligned register value
    pcAligned: assert property (
        @(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00
    ) else $error("nextPcUnit: PC not word-aligned");

endmodule

`default_nettype wire

// File: logic/regFile.sv
`default_nettype none

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  legPkg::regIdxT rdIdxA,
    input  legPkg::regIdxT rdIdxB,
    input  legPkg::regIdxT wrIdx,
    input  logic           wrEn,
    input  legPkg::wordT   wrData,
    output legPkg::wordT   rdDataA,
    output legPkg::wordT   rdDataB
);
    import legPkg::*;

    wordT regs [32];  // Entry 31 is never written or read
    logic wrAllowed;

    assign wrAllowed = rstN && wrEn && (wrIdx != ZERO_REG);

    always_ff @(posedge clk) begin
        if (wrAllowed) begin
            regs[wrIdx] <= wrData;
        end
    end

    // Asynchronous reads, XZR reads as zero
    always_comb begin
        if (rdIdxA == ZERO_REG) begin
            rdDataA = '0;
        end else begin
            rdDataA = regs[rdIdxA];
        end
    end

    always_comb begin
        if (rdIdxB == ZERO_REG) begin
            rdDataB = '0;
        end else begin
            rdDataB = regs[rdIdxB];
        end
    end

endmodule

`default_nettype wire

// File: sources.f
logic/legPkg.sv
logic/controlDecoder.sv
logic/regFile.sv
logic/aluUnit.sv
logic/nextPcUnit.sv
logic/cpuTop.sv
tb/cpuTopTb.sv

// File: tb/cpuTopTb.sv
`default_nettype none

module cpuTopTb;
    timeunit 1ns;
    timeprecision 1ps;

    import legPkg::*;

    localparam wordT RESET_PC     = 64'h400;
    localparam int   RESET_CYCLES = 8;
    localparam int   NUM_TESTS    = 7;
    localparam int   MAX_PROG     = 16;
    localparam int   MAX_STORES   = 4;

    logic  clk;
    logic  rstN;
    wordT  imemAddr;
    instrT imemData;
    wordT  dmemAddr;
    wordT  dmemWrData;
    logic  dmemWrEn;
    wordT  dmemRdData;

    // Test table with one row per program
    string testName      [NUM_TESTS];
    instrT progMem       [NUM_TESTS][MAX_PROG];
    int    progLenTab    [NUM_TESTS];
    int    runCycles     [NUM_TESTS];
    wordT  expPc         [NUM_TESTS];
    int    expStoreCount [NUM_TESTS];
    wordT  expStoreAddr  [NUM_TESTS][MAX_STORES];
    wordT  expStoreData  [NUM_TESTS][MAX_STORES];
    logic  preloadEn     [NUM_TESTS];
    wordT  preloadAddr   [NUM_TESTS];
    wordT  preloadData   [NUM_TESTS];

    instrT       imem [MAX_PROG];
    int          progLen;
    wordT        fetchIdx;
    wordT        dmem [wordT];
    wordT        storeAddrQ [$];
    wordT        storeDataQ [$];
    logic        tableReady = 1'b0;
    int          watchdogCycles;
    logic [31:0] lcgState = 32'd51202;

    cpuTop #(
        .RESET_PC (RESET_PC)
    ) cpuTop_i (
        .clk        (clk),
        .rstN       (rstN),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .dmemAddr   (dmemAddr),
        .dmemWrData (dmemWrData),
        .dmemWrEn   (dmemWrEn),
        .dmemRdData (dmemRdData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // Unused slots hold an opcode of all zeros, which decodes to nothing
    function automatic instrT fillInstr(wordT addr);
        return {11'd0, addr[22:2] ^ addr[43:23] ^ {1'b0, addr[63:44]} ^ {19'd0, addr[1:0]}};
    endfunction

    function automatic wordT fillData(wordT addr);
        return {addr[31:0] ^ 32'h5A5A_0F0F, addr[63:32]};
    endfunction

    function automatic instrT asmAddi(int rd, int rn, int imm);
        return {OP_ADDI, 12'(imm), 5'(rn), 5'(rd)};
    endfunction

    function automatic instrT asmReg(logic [10:0] op, int rd, int rn, int rm);
        return {op, 5'(rm), 6'd0, 5'(rn), 5'(rd)};
    endfunction

    function automatic instrT asmMem(logic [10:0] op, int rt, int rn, int offset);
        return {op, 9'(offset), 2'b00, 5'(rn), 5'(rt)};
    endfunction

    function automatic instrT asmUncond(logic [5:0] op, int words);
        return {op, 26'(words)};
    endfunction

    function automatic instrT asmCond(logic [7:0] op, int words, int rt);
        return {op, 19'(words), 5'(rt)};
    endfunction

    function automatic instrT asmBr(int rn);
        return {OP_BR, 11'd0, 5'(rn), 5'(rn)};  // Register in both fields
    endfunction

    // Combinational instruction fetch
    always_comb begin
        fetchIdx = (imemAddr - RESET_PC) >> 2;
        if (fetchIdx < wordT'(progLen)) begin
            imemData = imem[fetchIdx[3:0]];
        end else begin
            imemData = fillInstr(imemAddr);
        end
    end

    always_comb begin
        if (dmem.exists(dmemAddr)) begin
            dmemRdData = dmem[dmemAddr];
        end else begin
            dmemRdData = fillData(dmemAddr);
        end
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // Stores commit at the edge closing their cycle
    always @(posedge clk) begin
        if (!rstN && dmemWrEn) begin
            abortRun("dmemWrEn was high while the core was held in reset");
        end else if (dmemWrEn) begin
            dmem[dmemAddr] = dmemWrData;
            storeAddrQ.push_back(dmemAddr);
            storeDataQ.push_back(dmemWrData);
        end
    end

    task automatic compareWord(input string name, input string what,
                               input wordT expected, input wordT actual);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch in %s: %s expected %h, actual %h",
                               name, what, expected, actual));
        end
    endtask

    task automatic comparePc(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch in %s: pc expected %h, actual %h",
                               name, expected, actual));
        end
    endtask

    task automatic compareCount(input string name, input int expected, input int actual);
        if (actual != expected) begin
            abortRun($sformatf("mismatch in %s: store count expected %0d, actual %0d",
                               name, expected, actual));
        end
    endtask

    task automatic startTest(input int t, input string name, input int cycles, input int pcIdx);
        testName[t]      = name;
        runCycles[t]     = cycles;
        expPc[t]         = RESET_PC + wordT'(4 * pcIdx);
        progLenTab[t]    = 0;
        expStoreCount[t] = 0;
        preloadEn[t]     = 1'b0;
    endtask

    task automatic addInstr(input int t, input instrT word);
        progMem[t][progLenTab[t]] = word;
        progLenTab[t]++;
    endtask

    task automatic addStore(input int t, input wordT addr, input wordT data);
        expStoreAddr[t][expStoreCount[t]] = addr;
        expStoreData[t][expStoreCount[t]] = data;
        expStoreCount[t]++;
    endtask

    // X2 holds -vb, so ADDS gives va - vb and SUBS gives va + vb
    task automatic buildCompareTest(input int t, input string name, input logic isSub,
                                    input int va, input int vb);
        longint bVal;
        longint res;
        logic   taken;
        bVal  = -longint'(vb);
        res   = isSub ? longint'(va) - bVal : longint'(va) + bVal;
        taken = (res < 0);
        startTest(t, name, taken ? 8 : 9, 11);
        addInstr(t, asmAddi(1, 31, va));
        addInstr(t, asmAddi(3, 31, vb));
        addInstr(t, asmReg(OP_SUBS, 2, 31, 3));
        addInstr(t, asmAddi(4, 31, 12'h080));
        addInstr(t, asmReg(isSub ? OP_SUBS : OP_ADDS, 9, 1, 2));
        addInstr(t, asmCond(OP_BLT, 4, 11));    // Cond field LT
        addInstr(t, asmAddi(5, 31, 12'h011));   // Fall-through marker
        addInstr(t, asmMem(OP_STUR, 5, 4, 0));
        addInstr(t, asmUncond(OP_B, 3));
        addInstr(t, asmAddi(5, 31, 12'h022));   // Taken marker
        addInstr(t, asmMem(OP_STUR, 5, 4, 8));
        if (taken) begin
            addStore(t, 64'h088, 64'h022);
        end else begin
            addStore(t, 64'h080, 64'h011);
        end
    endtask

    task automatic buildTable();
        int   immA;
        int   immB;
        int   offset;
        wordT loadVal;
        immA    = int'(lcgNext() >> 20);
        immB    = int'(lcgNext() >> 20);
        offset  = int'(lcgNext() >> 27) * 8 - 128;
        loadVal = {lcgNext(), lcgNext()};

        startTest(0, "addiStore", 4, 4);
        addInstr(0, asmAddi(1, 31, immA));
        addInstr(0, asmAddi(2, 1, immB));
        addInstr(0, asmAddi(3, 31, 12'h100));
        addInstr(0, asmMem(OP_STUR, 2, 3, offset));
        addStore(0, 64'h100 + wordT'(longint'(offset)), wordT'(immA) + wordT'(immB));

        buildCompareTest(1, "addsLessThan", 1'b0, 3, 8);
        buildCompareTest(2, "subsNotLess", 1'b1, 3, 8);

        startTest(3, "cbzBranch", 7, 9);
        addInstr(3, asmAddi(1, 31, 0));
        addInstr(3, asmAddi(2, 31, 7));
        addInstr(3, asmAddi(4, 31, 12'h040));
        addInstr(3, asmCond(OP_CBZ, 3, 2));     // Falls through on nonzero X2
        addInstr(3, asmMem(OP_STUR, 2, 4, 0));
        addInstr(3, asmCond(OP_CBZ, 3, 1));     // Taken on zero X1
        addInstr(3, asmMem(OP_STUR, 4, 4, 8));
        addInstr(3, asmMem(OP_STUR, 4, 4, 16));
        addInstr(3, asmMem(OP_STUR, 1, 4, 24));
        addStore(3, 64'h040, 64'd7);
        addStore(3, 64'h058, 64'd0);

        startTest(4, "blReturn", 7, 13);
        addInstr(4, asmAddi(4, 31, 12'h200));
        addInstr(4, asmUncond(OP_BL, 4));
        addInstr(4, asmMem(OP_STUR, 30, 4, 0));
        addInstr(4, asmUncond(OP_B, 10));
        addInstr(4, asmAddi(7, 31, 7));         // Never reached
        addInstr(4, asmAddi(6, 31, 12'h033));
        addInstr(4, asmMem(OP_STUR, 6, 4, 8));
        addInstr(4, asmBr(30));
        addStore(4, 64'h208, 64'h033);
        addStore(4, 64'h200, RESET_PC + 64'd8);  // Link is the PC after BL

        startTest(5, "loadStore", 5, 5);
        preloadEn[5]   = 1'b1;
        preloadAddr[5] = 64'h300;
        preloadData[5] = loadVal;
        addInstr(5, asmAddi(4, 31, 12'h300));
        addInstr(5, asmMem(OP_LDUR, 7, 4, 0));
        addInstr(5, asmMem(OP_LDUR, 8, 4, -16));
        addInstr(5, asmMem(OP_STUR, 7, 4, 8));
        addInstr(5, asmMem(OP_STUR, 8, 4, 16));
        addStore(5, 64'h308, loadVal);
        addStore(5, 64'h310, fillData(64'h2F0));

        // A store sits on the bus for the whole reset
        startTest(6, "resetNop", 4, 4);
        addInstr(6, asmMem(OP_STUR, 31, 31, 8));
        addInstr(6, 32'hFFFF_FFFF);
        addInstr(6, 32'hD400_0001);
        addInstr(6, 32'h0000_0000);
        addStore(6, 64'h008, 64'd0);

        watchdogCycles = 20;
        for (int t = 0; t < NUM_TESTS; t++) begin
            watchdogCycles += runCycles[t] + RESET_CYCLES + 2;
        end
    endtask

    task automatic loadProgram(input int t);
        progLen = progLenTab[t];
        for (int i = 0; i < MAX_PROG; i++) begin
            imem[i] = progMem[t][i];
        end
        dmem.delete();
        storeAddrQ.delete();
        storeDataQ.delete();
        if (preloadEn[t]) begin
            dmem[preloadAddr[t]] = preloadData[t];
        end
    endtask

    task automatic resetAndLoad(input int t);
        @(posedge clk);
        rstN <= 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                rstN <= 1'b1;
            end
            @(negedge clk);
            if (i == 0) begin
                loadProgram(t);  // Previous program may still store at the first edge
            end
            comparePc(testName[t], RESET_PC, imemAddr);
        end
    endtask

    task automatic runAndCheck(input int t);
        repeat (runCycles[t]) @(posedge clk);
        @(negedge clk);
        comparePc(testName[t], expPc[t], imemAddr);
        compareCount(testName[t], expStoreCount[t], storeAddrQ.size());
        for (int i = 0; i < expStoreCount[t]; i++) begin
            compareWord(testName[t], "store address", expStoreAddr[t][i], storeAddrQ[i]);
            compareWord(testName[t], "store data", expStoreData[t][i], storeDataQ[i]);
        end
    endtask

    initial begin
        wait (tableReady);
        repeat (watchdogCycles) @(posedge clk);
        abortRun("simulation timed out before all tests finished");
    end

    initial begin
        rstN    = 1'b0;
        progLen = 0;
        buildTable();
        tableReady = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            resetAndLoad(t);
            runAndCheck(t);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
